/* build.f */
design/seg7_pkg.sv
design/capture_pkg.sv
design/sample_buffer.sv
design/bcd_counter.sv
design/display_sequencer.sv
design/digit_scanner.sv
design/seg7_regs.sv
design/seg7_display_top.sv
bench/seg7_display_tb.sv

/* Bender.yml */
package:
  name: seg7_display

sources:
  # packages first, then the blocks, then the top level
  - files:
      - design/seg7_pkg.sv
      - design/capture_pkg.sv
      - design/sample_buffer.sv
      - design/bcd_counter.sv
      - design/display_sequencer.sv
      - design/digit_scanner.sv
      - design/seg7_regs.sv
      - design/seg7_display_top.sv

  # simulation only
  - target: test
    files:
      - bench/seg7_display_tb.sv

/* bench/seg7_display_tb.sv */
`default_nettype none

module seg7_display_tb
    import capture_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_period  = 4;
    localparam int depth       = 16;
    localparam int dwell_test  = 20;
    localparam int scan_test   = 3;
    localparam int conv_worst  = 10001;                 // |field| saturated at 9999, plus 2
    localparam int sample_cyc  = 1 + conv_worst + dwell_test + 1 + 4;
    localparam int scan_digits = 12;                    // three full rotations
    localparam int scan_cyc    = 2 * scan_digits * (scan_test + 1);
    localparam int watch_cyc   = 4 * depth * sample_cyc + scan_cyc + 1000;
    localparam int ack_limit   = 16;
    localparam int poll_limit  = 12000;                 // two cycles per status read
    localparam int scan_limit  = 64;

    logic         clk;
    logic         rst_n;
    logic         sample_valid;
    sample_pair_t sample;
    wb_req_t      wb_req;
    wb_rsp_t      wb_rsp;
    logic [3:0]   dig;
    logic [7:0]   seg;

    int x_field [depth];                                // displayed fields as loaded
    int y_field [depth];
    int errors;

    seg7_display_top #(
        .depth       (depth),
        .field_shift (6),
        .dwell_reset (26'd49_999_999),
        .scan_reset  (20'd100_000)
    ) UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample_valid (sample_valid),
        .sample       (sample),
        .wb_req       (wb_req),
        .wb_rsp       (wb_rsp),
        .dig          (dig),
        .seg          (seg)
    );

    always #(clk_period / 2) clk = ~clk;

    initial begin
        #(watch_cyc * clk_period);
        $display("watchdog expired before the tests finished");
        $display("Test failed");
        $fatal(1);
    end

    ////////////////////////////////////////////////////////////
    // checking helpers
    ////////////////////////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            errors++;
            $display("ERR %s: expected %h, actual %h", name, exp, act);
            abort_run("value mismatch");
        end
    endtask

    function automatic logic [16:0] expect_digits(input int v);
        int          mag;
        logic [16:0] d;
        mag = (v < 0) ? -v : v;
        if (mag > 9999) mag = 9999;                     // readout saturates
        d[16:13] = 4'(mag / 1000);
        d[12:9]  = 4'((mag / 100) % 10);
        d[8:5]   = 4'((mag / 10) % 10);
        d[4:1]   = 4'(mag % 10);
        d[0]     = (v < 0);
        return d;
    endfunction

    function automatic logic [7:0] seg_pattern(input logic [3:0] v);
        case (v)
            4'd0:    return 8'hC0;
            4'd1:    return 8'hF9;
            4'd2:    return 8'hA4;
            4'd3:    return 8'hB0;
            4'd4:    return 8'h99;
            4'd5:    return 8'h92;
            4'd6:    return 8'h82;
            4'd7:    return 8'hF8;
            4'd8:    return 8'h80;
            4'd9:    return 8'h90;
            default: return 8'hFF;
        endcase
    endfunction

    function automatic logic [3:0] pattern_for(input int pos);
        case (pos)
            0:       return 4'b1110;
            1:       return 4'b1101;
            2:       return 4'b1011;
            default: return 4'b0111;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // bus and stimulus
    ////////////////////////////////////////////////////////////

    task automatic wb_access(input logic we, input logic [1:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        int waited;
        waited = 0;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = wdat;
        do begin
            @(posedge clk);
            #1;
            waited++;
        end while (!wb_rsp.ack && waited < ack_limit);
        if (!wb_rsp.ack) abort_run("wishbone slave never acknowledged the access");
        rdat   = wb_rsp.dat;
        wb_req = '0;                                    // end of the cycle
        @(posedge clk);
        #1;
        check_value("wishbone single ack", 32'd0, 32'(wb_rsp.ack));
    endtask

    task automatic write_reg(input logic [1:0] adr, input logic [31:0] wdat);
        logic [31:0] unused;
        wb_access(1'b1, adr, wdat, unused);
    endtask

    task automatic read_reg(input logic [1:0] adr, output logic [31:0] rdat);
        wb_access(1'b0, adr, 32'd0, rdat);
    endtask

    // places a 16-bit field at bits 21:6 with random bits around it
    function automatic logic [31:0] pack_field(input logic [15:0] f);
        logic [31:0] r;
        r = $urandom();
        return {r[31:22], f, r[5:0]};
    endfunction

    task automatic drive_pair(input logic [31:0] xw, input logic [31:0] yw);
        sample.x     = xw;
        sample.y     = yw;
        sample_valid = 1'b1;
        @(posedge clk);
        #1;
        sample_valid = 1'b0;
    endtask

    task automatic load_window();
        int         fixed_x [6];
        logic [15:0] fx;
        logic [15:0] fy;
        fixed_x = '{0, 7, 9999, 12345, -5, -32768};
        for (int i = 0; i < depth; i++) begin
            fx = (i < 6) ? 16'(fixed_x[i]) : 16'($urandom());
            fy = 16'($urandom());
            fy[15] = i[0];                              // odd indices negative on y
            x_field[i] = $signed(fx);
            y_field[i] = $signed(fy);
            drive_pair(pack_field(fx), pack_field(fy));
        end
    endtask

    task automatic wait_holding(input logic level, output logic [31:0] st);
        int polls;
        polls = 0;
        read_reg(reg_status, st);
        while (st[1] !== level) begin
            polls++;
            if (polls > poll_limit) abort_run("holding flag never changed while polling status");
            else read_reg(reg_status, st);
        end
    endtask

    // lets the sample under way finish so that a new control word applies
    task automatic skip_current_hold();
        logic [31:0] st;
        wait_holding(1'b1, st);
        wait_holding(1'b0, st);
    endtask

    task automatic run_pass(input string name, input logic use_y, input int count,
                            input int first_idx);
        logic [31:0] st;
        int          idx;
        int          v;
        idx = first_idx;
        for (int k = 0; k < count; k++) begin
            wait_holding(1'b1, st);
            check_value({name, " cur_idx"}, idx, st[7:4]);
            v = use_y ? y_field[idx] : x_field[idx];
            check_value({name, " digits"}, expect_digits(v), {st[31:16], st[8]});
            wait_holding(1'b0, st);
            idx = (idx + 1) % depth;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset();
        logic [31:0] rd;
        repeat (10) @(posedge clk);
        #1;
        check_value("reset dig", 32'hF, dig);
        check_value("reset seg", 32'hFF, seg);
        rst_n = 1'b1;
        read_reg(reg_dwell, rd);
        check_value("reset dwell", 32'd49_999_999, rd);
        read_reg(reg_scan, rd);
        check_value("reset scan", 32'd100_000, rd);
        read_reg(reg_status, rd);
        check_value("reset status", 32'd0, rd);
    endtask

    task automatic test_registers();
        logic [31:0] rd;
        write_reg(reg_ctrl, 32'hFFFF_FFFE);             // unused bits must read back zero
        read_reg(reg_ctrl, rd);
        check_value("registers ctrl", 32'd2, rd);
        write_reg(reg_ctrl, 32'd0);
        write_reg(reg_dwell, dwell_test);
        read_reg(reg_dwell, rd);
        check_value("registers dwell", dwell_test, rd);
        write_reg(reg_scan, scan_test);
        read_reg(reg_scan, rd);
        check_value("registers scan", scan_test, rd);
        write_reg(reg_status, 32'hFFFF_FFFF);
        read_reg(reg_status, rd);
        check_value("registers status", 32'd0, rd);
    endtask

    task automatic test_channel_x();
        logic [31:0] rd;
        load_window();
        read_reg(reg_status, rd);
        check_value("conv_x filled", 32'd1, 32'(rd[0]));
        write_reg(reg_ctrl, 32'd1);
        run_pass("conv_x", 1'b0, depth, 0);
    endtask

    task automatic test_channel_y();
        write_reg(reg_ctrl, 32'd3);
        skip_current_hold();                            // index 0 was latched on x
        run_pass("chan_y", 1'b1, 4, 1);
    endtask

    task automatic test_scan();
        logic [31:0] st;
        logic [31:0] rd;
        logic [3:0]  pat;
        logic [7:0]  exp_seg;
        int          pos;
        int          lit;
        int          waited;
        write_reg(reg_ctrl, 32'd2);                     // stop after this hold
        skip_current_hold();
        read_reg(reg_status, st);
        @(negedge clk);
        pat    = dig;
        waited = 0;
        while (dig === pat && waited < scan_limit) begin
            @(negedge clk);
            waited++;
        end
        if (dig === pat) abort_run("dig never changed during the scan test");
        pos = -1;
        for (int p = 0; p < 4; p++) begin
            if (dig === pattern_for(p)) pos = p;
        end
        if (pos < 0) abort_run("dig does not enable exactly one digit");
        for (int n = 0; n < scan_digits; n++) begin
            check_value("scan dig order", pattern_for(pos), dig);
            pat     = dig;
            exp_seg = seg_pattern(st[16 + 4 * pos +: 4]);
            if (pos == 3 && st[8]) exp_seg[7] = 1'b0;   // sign on the leftmost dp
            lit = 0;
            while (dig === pat && lit <= scan_limit) begin
                check_value("scan seg", exp_seg, seg);
                lit++;
                @(negedge clk);
            end
            check_value("scan lit cycles", scan_test + 1, lit);
            pos = (pos + 1) % 4;
        end
        // a sequencer still running would have finished another sample by now
        repeat (sample_cyc) @(posedge clk);
        #1;
        read_reg(reg_status, rd);
        check_value("scan stopped", st, rd);
    endtask

    task automatic test_freeze();
        for (int i = 0; i < 8; i++) begin
            drive_pair($urandom(), $urandom());         // must be dropped
            @(posedge clk);
            #1;
        end
        write_reg(reg_ctrl, 32'd1);
        run_pass("freeze", 1'b0, depth, 6);             // stopped after index 5
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        sample_valid = 1'b0;
        sample       = '0;
        wb_req       = '0;
        errors       = 0;
        void'($urandom(32'haaa));

        test_reset();
        test_registers();
        test_channel_x();
        test_channel_y();
        test_scan();
        test_freeze();

        if (errors == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

/* design/seg7_display_top.sv */
`default_nettype none

module seg7_display_top
    import seg7_pkg::*;
    import capture_pkg::*;
#(
    parameter int          depth       = 16,
    parameter int          field_shift = 6,
    parameter logic [25:0] dwell_reset = 26'd49_999_999,
    parameter logic [19:0] scan_reset  = 20'd100_000
) (
    input  wire logic         clk,
    input  wire logic         rst_n,
    input  wire logic         sample_valid,
    input  wire sample_pair_t sample,
    input  wire wb_req_t      wb_req,
    output wb_rsp_t           wb_rsp,
    output logic [3:0]        dig,
    output logic [7:0]        seg
);

    localparam int idx_w = $clog2(depth);

    logic             filled;
    logic [idx_w-1:0] rd_idx;
    sample_pair_t     rd_data;
    logic [idx_w-1:0] cur_idx;
    logic             holding;
    bcd_digits_t      shown;
    ctrl_t            ctrl;
    logic [25:0]      dwell_len;
    logic [19:0]      scan_len;

    sample_buffer #(.depth(depth)) u_buf (
        .clk(clk), .rst_n(rst_n),
        .sample_valid(sample_valid), .sample(sample),
        .rd_idx(rd_idx), .rd_data(rd_data), .filled(filled)
    );

    display_sequencer #(.depth(depth), .field_shift(field_shift)) u_seq (
        .clk(clk), .rst_n(rst_n), .filled(filled), .ctrl(ctrl),
        .dwell_len(dwell_len), .rd_idx(rd_idx), .rd_data(rd_data),
        .shown(shown), .holding(holding), .cur_idx(cur_idx)
    );

    digit_scanner u_scan (
        .clk(clk), .rst_n(rst_n), .shown(shown),
        .scan_len(scan_len), .dig(dig), .seg(seg)
    );

    seg7_regs #(.dwell_reset(dwell_reset), .scan_reset(scan_reset)) u_regs (
        .clk(clk), .rst_n(rst_n), .wb_req(wb_req), .wb_rsp(wb_rsp),
        .ctrl(ctrl), .dwell_len(dwell_len), .scan_len(scan_len),
        .filled(filled), .holding(holding), .cur_idx(4'(cur_idx)), .shown(shown)
    );

endmodule

`default_nettype wire

/* design/seg7_regs.sv */
`default_nettype none

module seg7_regs
    import seg7_pkg::*;
    import capture_pkg::*;
#(
    parameter logic [25:0] dwell_reset = 26'd49_999_999,
    parameter logic [19:0] scan_reset  = 20'd100_000
) (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire wb_req_t     wb_req,
    output wb_rsp_t          wb_rsp,
    output ctrl_t            ctrl,
    output logic [25:0]      dwell_len,
    output logic [19:0]      scan_len,
    input  wire logic        filled,
    input  wire logic        holding,
    input  wire logic [3:0]  cur_idx,
    input  wire bcd_digits_t shown
);

    logic        ack;
    logic [31:0] rd_dat;
    logic        access;
    logic [31:0] status;
    logic [31:0] rd_word;

    // a held stb alternates ack, so each second cycle is a fresh access
    assign access = wb_req.cyc && wb_req.stb && !ack;

    assign status = {shown.d3, shown.d2, shown.d1, shown.d0,
                     7'd0, shown.neg, cur_idx, 2'd0, holding, filled};

    always_comb begin
        case (wb_req.adr)
            reg_ctrl:  rd_word = 32'(ctrl);
            reg_dwell: rd_word = 32'(dwell_len);
            reg_scan:  rd_word = 32'(scan_len);
            default:   rd_word = status;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // bus side
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack       <= 1'b0;
            ctrl      <= '0;
            dwell_len <= dwell_reset;
            scan_len  <= scan_reset;
        end else begin
            ack <= access;
            if (access && wb_req.we) begin
                case (wb_req.adr)
                    reg_ctrl:  ctrl      <= ctrl_t'(wb_req.dat[1:0]);
                    reg_dwell: dwell_len <= wb_req.dat[25:0];
                    reg_scan:  scan_len  <= wb_req.dat[19:0];
                    default: ;                  // status is read only
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) rd_dat <= rd_word;          // sampled with the ack edge
    end

    assign wb_rsp.ack = ack;
    assign wb_rsp.dat = rd_dat;

endmodule

`default_nettype wire

/* design/digit_scanner.sv */
`default_nettype none

module digit_scanner
    import seg7_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire bcd_digits_t           shown,
    input  wire logic [19:0]           scan_len,
    output logic [num_digits-1:0]      dig,
    output logic [7:0]                 seg
);

    localparam int ptr_w = $clog2(num_digits);

    logic [19:0]      scan_cnt;
    logic [ptr_w-1:0] cur;                      // digit being lit
    logic             active;                   // low until the first scan step
    logic [3:0]       val;
    logic [7:0]       code;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active   <= 1'b0;
            cur      <= '0;
            scan_cnt <= '0;
        end else if (!active) begin
            active   <= 1'b1;                   // d0 comes up first
            scan_cnt <= '0;
        end else if (scan_cnt >= scan_len) begin
            cur      <= cur + 1'b1;             // d0 -> d1 -> d2 -> d3 -> d0
            scan_cnt <= '0;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // segment lookup
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (cur)
            2'd0:    val = shown.d0;
            2'd1:    val = shown.d1;
            2'd2:    val = shown.d2;
            default: val = shown.d3;
        endcase
    end

    always_comb begin
        code = (val <= 4'd9) ? seg_code[val] : seg_blank;
        if (cur == 2'd3 && shown.neg) code[7] = 1'b0;   // sign on leftmost dp
    end

    // dig and seg both follow cur, so they switch together
    assign dig = active ? ~(num_digits'(1) << cur) : dig_off;
    assign seg = active ? code : seg_blank;

    a_one_digit: assert property (
        @(posedge clk) disable iff (!rst_n)
        active |=> active && $onehot(~dig)
    );

endmodule

`default_nettype wire

/* design/display_sequencer.sv */
`default_nettype none

module display_sequencer
    import seg7_pkg::*;
    import capture_pkg::*;
#(
    parameter int depth       = 16,
    parameter int field_shift = 6
) (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     filled,
    input  wire ctrl_t                    ctrl,
    input  wire logic [25:0]              dwell_len,
    output logic [$clog2(depth)-1:0]      rd_idx,
    input  wire sample_pair_t             rd_data,
    output bcd_digits_t                   shown,
    output logic                          holding,
    output logic [$clog2(depth)-1:0]      cur_idx
);

    localparam int idx_w = $clog2(depth);

    typedef enum logic [1:0] {
        st_idle,
        st_prepare,
        st_convert,
        st_hold
    } state_t;

    state_t             state;
    logic [25:0]        hold_cnt;
    logic signed [31:0] chan;
    field_t             field;
    logic               start;
    logic               done;
    bcd_digits_t        digits;

    ////////////////////////////////////////////////////////////
    // field select and converter
    ////////////////////////////////////////////////////////////

    assign rd_idx  = cur_idx;
    assign chan    = ctrl.chan_sel ? rd_data.y : rd_data.x;
    assign field   = chan[field_shift +: 16];   // fixed-point window
    assign start   = (state == st_prepare);
    assign holding = (state == st_hold);

    bcd_counter u_bcd (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .field  (field),
        .digits (digits),
        .done   (done)
    );

    ////////////////////////////////////////////////////////////
    // walk through the window
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_idle;
            hold_cnt <= '0;
            cur_idx  <= '0;
            shown    <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (filled && ctrl.enable) state <= st_prepare;
                end
                st_prepare: state <= st_convert;        // start fires here
                st_convert: begin
                    if (done) begin
                        shown    <= digits;
                        hold_cnt <= '0;
                        state    <= st_hold;
                    end
                end
                st_hold: begin
                    if (hold_cnt == dwell_len) begin
                        if (cur_idx == idx_w'(depth - 1)) cur_idx <= '0;
                        else cur_idx <= cur_idx + 1'b1;
                        state <= ctrl.enable ? st_prepare : st_idle;
                    end else begin
                        hold_cnt <= hold_cnt + 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // one conversion at a time
    a_no_restart: assert property (
        @(posedge clk) disable iff (!rst_n)
        start |=> (!start until done)
    );

endmodule

`default_nettype wire

/* design/bcd_counter.sv */
`default_nettype none

module bcd_counter
    import seg7_pkg::*;
    import capture_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst_n,
    input  wire logic   start,
    input  wire field_t field,
    output bcd_digits_t digits,
    output logic        done
);

    logic [16:0] mag_full;
    logic [13:0] mag_sat;
    logic [13:0] mag;
    logic [13:0] count;
    logic        busy;

    // |field| needs 17 bits for -32768
    assign mag_full = field[15] ? (17'd0 - {field[15], field}) : {1'b0, field};
    assign mag_sat  = (mag_full > 17'(bcd_max)) ? 14'(bcd_max) : mag_full[13:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            done   <= 1'b0;
            mag    <= '0;
            count  <= '0;
            digits <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy       <= 1'b1;
                mag        <= mag_sat;
                count      <= '0;
                digits     <= '0;
                digits.neg <= field[15];
            end else if (busy) begin
                if (count == mag) begin
                    busy <= 1'b0;
                    done <= 1'b1;               // digits are final now
                end else begin
                    count <= count + 1'b1;
                    // ripple the decimal carry up through the digits
                    if (digits.d0 != 4'd9) begin
                        digits.d0 <= digits.d0 + 4'd1;
                    end else begin
                        digits.d0 <= 4'd0;
                        if (digits.d1 != 4'd9) begin
                            digits.d1 <= digits.d1 + 4'd1;
                        end else begin
                            digits.d1 <= 4'd0;
                            if (digits.d2 != 4'd9) begin
                                digits.d2 <= digits.d2 + 4'd1;
                            end else begin
                                digits.d2 <= 4'd0;
                                digits.d3 <= digits.d3 + 4'd1;  // capped by bcd_max
                            end
                        end
                    end
                end
            end
        end
    end

    a_bcd_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        digits.d0 <= 4'd9 && digits.d1 <= 4'd9 && digits.d2 <= 4'd9 && digits.d3 <= 4'd9
    );

endmodule

`default_nettype wire

/* design/sample_buffer.sv */
`default_nettype none

module sample_buffer
    import capture_pkg::*;
#(
    parameter int depth = 16
) (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     sample_valid,
    input  wire sample_pair_t             sample,
    input  wire logic [$clog2(depth)-1:0] rd_idx,
    output sample_pair_t                  rd_data,
    output logic                          filled
);

    localparam int idx_w = $clog2(depth);

    sample_pair_t     mem [depth];
    logic [idx_w-1:0] wr_ptr;
    logic             wr_en;

    assign wr_en = sample_valid && !filled;     // no back-pressure, late pairs dropped

    ////////////////////////////////////////////////////////////
    // write side
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            filled <= 1'b0;
        end else if (wr_en) begin
            if (wr_ptr == idx_w'(depth - 1)) begin
                wr_ptr <= '0;
                filled <= 1'b1;                 // window frozen until reset
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= sample;
        end
    end

    ////////////////////////////////////////////////////////////
    // read side
    ////////////////////////////////////////////////////////////

    assign rd_data = mem[rd_idx];               // combinational, same cycle

    // once the window is full it stays full and the pointer never moves
    a_frozen: assert property (
        @(posedge clk) disable iff (!rst_n)
        filled |=> filled && $stable(wr_ptr)
    );

endmodule

`default_nettype wire

/* design/capture_pkg.sv */
`default_nettype none

package capture_pkg;

    // one pair from the upstream processing block
    typedef struct packed {
        logic signed [31:0] x;
        logic signed [31:0] y;
    } sample_pair_t;

    typedef logic signed [15:0] field_t;        // fixed-point slice that gets displayed

    ////////////////////////////////////////////////////////////
    // wishbone classic
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [1:0]  adr;                       // word address
        logic [31:0] dat;                       // write data
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;                       // read data
    } wb_rsp_t;

    // enable sits in bit 0 of the control word, chan_sel in bit 1
    typedef struct packed {
        logic chan_sel;                         // 0 = x, 1 = y
        logic enable;
    } ctrl_t;

    localparam logic [1:0] reg_ctrl   = 2'd0;
    localparam logic [1:0] reg_dwell  = 2'd1;
    localparam logic [1:0] reg_scan   = 2'd2;
    localparam logic [1:0] reg_status = 2'd3;

endpackage

`default_nettype wire

/* design/seg7_pkg.sv */
`default_nettype none

package seg7_pkg;

    ////////////////////////////////////////////////////////////
    // display geometry
    ////////////////////////////////////////////////////////////

    localparam int num_digits = 4;
    localparam int unsigned bcd_max = 9999;     // readout saturates here

    // magnitude in BCD, sign kept apart for the d3 decimal point
    typedef struct packed {
        logic       neg;                        // value was negative
        logic [3:0] d3;                         // thousands
        logic [3:0] d2;                         // hundreds
        logic [3:0] d1;                         // tens
        logic [3:0] d0;                         // units
    } bcd_digits_t;

    ////////////////////////////////////////////////////////////
    // segment patterns
    ////////////////////////////////////////////////////////////

    // common anode, active low, bits are dp g f e d c b a
    localparam logic [7:0] seg_code [10] = '{
        8'hC0,                                  // 0
        8'hF9,                                  // 1
        8'hA4,                                  // 2
        8'hB0,                                  // 3
        8'h99,                                  // 4
        8'h92,                                  // 5
        8'h82,                                  // 6
        8'hF8,                                  // 7
        8'h80,                                  // 8
        8'h90                                   // 9
    };

    localparam logic [7:0] seg_blank = 8'hFF;   // all segments dark
    localparam logic [num_digits-1:0] dig_off = '1;

endpackage

`default_nettype wire
